/* common/cmac_pkg.sv */
/*
 * Shared widths and bus types for the int16 convolution MAC cell.
 * Pair i of a flat operand bus sits at bits i*16 +: 16, pair 0 lowest.
 * Widths are sized for 64 signed 16x16 products with no overflow.
 * Only the int16 path exists here; fp16, int8 and winograd are absent.
 */
`default_nettype none

package cmac_pkg;

  // ==============================
  // widths and counts
  // ==============================
  localparam int OPND_W         = 16;
  localparam int NUM_PAIRS      = 64;
  localparam int NUM_LANES      = 8;
  localparam int PAIRS_PER_LANE = NUM_PAIRS / NUM_LANES;
  localparam int PROD_W         = 2 * OPND_W;           // full signed product
  localparam int LANE_SUM_W     = PROD_W + 3;           // 8 products per lane
  localparam int SUM_W          = PROD_W + 6;           // 64 products overall
  localparam int VEC_W          = NUM_PAIRS * OPND_W;

  // ==============================
  // bus types
  // ==============================

  // flat operand bus as seen at the cell boundary
  typedef logic [VEC_W-1:0] opnd_vec_t;

  // one data operand and its matching weight
  typedef struct packed {
    logic signed [OPND_W-1:0] dat;
    logic signed [OPND_W-1:0] wt;
  } opnd_pair_t;

  // operands for one multiply lane
  typedef struct packed {
    opnd_pair_t [PAIRS_PER_LANE-1:0] pair;
  } lane_ops_t;

  // registered partial sum leaving a lane
  typedef struct packed {
    logic                         pvld;
    logic signed [LANE_SUM_W-1:0] sum;
  } lane_sum_t;

endpackage

`default_nettype wire

/* mac/cmac_operand_stage.sv */
/*
 * First pipeline stage: captures both operand buses on in_pvld.
 * Operand registers hold their value while in_pvld is low.
 * Lane k is handed pairs 8k..8k+7, data i always with weight i.
 */
`timescale 1ns/1ns
`default_nettype none

module cmac_operand_stage (
  input  wire                        nvdla_core_clk,
  input  wire                        rst_n,
  input  wire                        in_pvld,
  input  wire  cmac_pkg::opnd_vec_t  dat_actv_data,
  input  wire  cmac_pkg::opnd_vec_t  wt_actv_data,
  output logic                       ops_pvld,
  output cmac_pkg::lane_ops_t        lane_ops [cmac_pkg::NUM_LANES]
);

  cmac_pkg::opnd_vec_t dat_q;   // captured data operands
  cmac_pkg::opnd_vec_t wt_q;    // captured weight operands

  // ==============================
  // capture registers
  // ==============================
  always_ff @(posedge nvdla_core_clk or negedge rst_n) begin
    if (!rst_n) begin
      ops_pvld <= 1'b0;
    end else begin
      ops_pvld <= in_pvld;      // one stage behind the input strobe
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (in_pvld) begin
      dat_q <= dat_actv_data;
      wt_q  <= wt_actv_data;
    end
  end

  // ==============================
  // regroup into lanes
  // ==============================
  always_comb begin
    int unsigned idx;
    for (int k = 0; k < cmac_pkg::NUM_LANES; k++) begin
      for (int j = 0; j < cmac_pkg::PAIRS_PER_LANE; j++) begin
        idx = k * cmac_pkg::PAIRS_PER_LANE + j;   // pair number in the flat bus
        lane_ops[k].pair[j].dat = dat_q[idx*cmac_pkg::OPND_W +: cmac_pkg::OPND_W];
        lane_ops[k].pair[j].wt  = wt_q[idx*cmac_pkg::OPND_W +: cmac_pkg::OPND_W];
      end
    end
  end

  // ==============================
  // checks
  // ==============================

  // X on a qualified operand would poison every lane downstream
  a_opnd_known : assert property (
    @(posedge nvdla_core_clk) disable iff (!rst_n)
      in_pvld |-> !$isunknown({dat_actv_data, wt_actv_data})
  ) else $error("operand bus carries unknown bits while in_pvld is high");

endmodule

`default_nettype wire

/* mac/cmac_mult_lane.sv */
/*
 * One multiply lane: eight signed 16x16 products summed to 35 bits.
 * The sum register loads only on ops_pvld and holds otherwise.
 * 35 bits cover eight worst case products of -32768 * -32768.
 */
`timescale 1ns/1ns
`default_nettype none

module cmac_mult_lane (
  input  wire                        nvdla_core_clk,
  input  wire                        rst_n,
  input  wire                        ops_pvld,
  input  wire  cmac_pkg::lane_ops_t  lane_ops,
  output cmac_pkg::lane_sum_t        lane_sum
);

  logic signed [cmac_pkg::PROD_W-1:0]     prod   [cmac_pkg::PAIRS_PER_LANE];
  logic signed [cmac_pkg::LANE_SUM_W-1:0] ext    [cmac_pkg::PAIRS_PER_LANE];
  logic signed [cmac_pkg::LANE_SUM_W-1:0] add_l1 [cmac_pkg::PAIRS_PER_LANE/2];
  logic signed [cmac_pkg::LANE_SUM_W-1:0] add_l2 [cmac_pkg::PAIRS_PER_LANE/4];
  logic signed [cmac_pkg::LANE_SUM_W-1:0] lane_total;
  logic signed [cmac_pkg::LANE_SUM_W-1:0] sum_q;
  logic                                   pvld_q;

  // ==============================
  // products and sign extension
  // ==============================
  always_comb begin
    for (int j = 0; j < cmac_pkg::PAIRS_PER_LANE; j++) begin
      prod[j] = lane_ops.pair[j].dat * lane_ops.pair[j].wt;   // signed 32-bit result
      ext[j]  = {{(cmac_pkg::LANE_SUM_W - cmac_pkg::PROD_W){prod[j][cmac_pkg::PROD_W-1]}},
                 prod[j]};
    end
  end

  // ==============================
  // adder tree, 8 -> 4 -> 2 -> 1
  // ==============================
  always_comb begin
    for (int j = 0; j < cmac_pkg::PAIRS_PER_LANE/2; j++) begin
      add_l1[j] = ext[2*j] + ext[2*j+1];
    end
    for (int j = 0; j < cmac_pkg::PAIRS_PER_LANE/4; j++) begin
      add_l2[j] = add_l1[2*j] + add_l1[2*j+1];
    end
    lane_total = add_l2[0] + add_l2[1];
  end

  // ==============================
  // lane registers
  // ==============================
  always_ff @(posedge nvdla_core_clk or negedge rst_n) begin
    if (!rst_n) begin
      pvld_q <= 1'b0;
    end else begin
      pvld_q <= ops_pvld;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (ops_pvld) begin
      sum_q <= lane_total;   // held between vectors
    end
  end

  assign lane_sum = '{pvld: pvld_q, sum: sum_q};

endmodule

`default_nettype wire

/* mac/cmac_sum_reduce.sv */
/*
 * Last pipeline stage: adds the eight lane sums into a 38-bit result.
 * Lane 0's strobe qualifies all lanes, which always move in lock step.
 * The result is sign extended and holds its value between strobes.
 */
`timescale 1ns/1ns
`default_nettype none

module cmac_sum_reduce (
  input  wire                               nvdla_core_clk,
  input  wire                               rst_n,
  input  wire  cmac_pkg::lane_sum_t         lane_sums [cmac_pkg::NUM_LANES],
  output logic                              mac_out_pvld,
  output logic signed [cmac_pkg::SUM_W-1:0] mac_out_data
);

  logic signed [cmac_pkg::SUM_W-1:0] ext    [cmac_pkg::NUM_LANES];
  logic signed [cmac_pkg::SUM_W-1:0] add_l1 [cmac_pkg::NUM_LANES/2];
  logic signed [cmac_pkg::SUM_W-1:0] add_l2 [cmac_pkg::NUM_LANES/4];
  logic signed [cmac_pkg::SUM_W-1:0] total;
  logic [cmac_pkg::NUM_LANES-1:0]    lane_pvld;
  logic                              sum_pvld;

  // ==============================
  // widen lane sums
  // ==============================
  always_comb begin
    for (int k = 0; k < cmac_pkg::NUM_LANES; k++) begin
      lane_pvld[k] = lane_sums[k].pvld;
      ext[k] = {{(cmac_pkg::SUM_W - cmac_pkg::LANE_SUM_W){lane_sums[k].sum[cmac_pkg::LANE_SUM_W-1]}},
                lane_sums[k].sum};
    end
  end

  assign sum_pvld = lane_pvld[0];   // stands for every lane

  // ==============================
  // three level adder tree
  // ==============================
  always_comb begin
    for (int k = 0; k < cmac_pkg::NUM_LANES/2; k++) begin
      add_l1[k] = ext[2*k] + ext[2*k+1];
    end
    for (int k = 0; k < cmac_pkg::NUM_LANES/4; k++) begin
      add_l2[k] = add_l1[2*k] + add_l1[2*k+1];
    end
    total = add_l2[0] + add_l2[1];
  end

  // ==============================
  // output registers
  // ==============================
  always_ff @(posedge nvdla_core_clk or negedge rst_n) begin
    if (!rst_n) begin
      mac_out_pvld <= 1'b0;
    end else begin
      mac_out_pvld <= sum_pvld;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (sum_pvld) begin
      mac_out_data <= total;
    end
  end

  // ==============================
  // checks
  // ==============================

  // lanes share one strobe upstream, a split here means a broken fan-out
  a_lane_pvld_agree : assert property (
    @(posedge nvdla_core_clk)
      (lane_pvld == '0) || (lane_pvld == '1)
  ) else $error("lane strobes disagree: %b", lane_pvld);

  // a lane strobe held in reset would push a result out at release
  a_no_pvld_in_reset : assert property (
    @(posedge nvdla_core_clk)
      !rst_n |-> (lane_pvld == '0)
  ) else $error("lane strobe high during reset: %b", lane_pvld);

endmodule

`default_nettype wire

/* hw/cmac_mac.sv */
/*
 * Int16 dot product of 64 operand pairs, fully pipelined.
 * One result strobe per input strobe, three register stages deep.
 * No back-pressure: the consumer takes the result in its strobe cycle.
 */
`timescale 1ns/1ns
`default_nettype none

module cmac_mac (
  input  wire                              nvdla_core_clk,
  input  wire                              rst_n,
  input  wire                              in_pvld,       // one vector per high cycle
  input  wire  cmac_pkg::opnd_vec_t        dat_actv_data,
  input  wire  cmac_pkg::opnd_vec_t        wt_actv_data,
  output logic                             mac_out_pvld,
  output logic signed [cmac_pkg::SUM_W-1:0] mac_out_data
);

  // ==============================
  // internal buses
  // ==============================
  logic                ops_pvld;
  cmac_pkg::lane_ops_t lane_ops  [cmac_pkg::NUM_LANES];
  cmac_pkg::lane_sum_t lane_sums [cmac_pkg::NUM_LANES];

  // ==============================
  // operand capture
  // ==============================
  cmac_operand_stage u_operand_stage (
    .nvdla_core_clk (nvdla_core_clk),
    .rst_n          (rst_n),
    .in_pvld        (in_pvld),
    .dat_actv_data  (dat_actv_data),
    .wt_actv_data   (wt_actv_data),
    .ops_pvld       (ops_pvld),
    .lane_ops       (lane_ops)
  );

  // ==============================
  // multiply lanes
  // ==============================
  for (genvar k = 0; k < cmac_pkg::NUM_LANES; k++) begin : g_lane
    // lane k covers pairs 8k .. 8k+7
    cmac_mult_lane u_mult_lane (
      .nvdla_core_clk (nvdla_core_clk),
      .rst_n          (rst_n),
      .ops_pvld       (ops_pvld),
      .lane_ops       (lane_ops[k]),
      .lane_sum       (lane_sums[k])
    );
  end

  // ==============================
  // final reduction
  // ==============================
  cmac_sum_reduce u_sum_reduce (
    .nvdla_core_clk (nvdla_core_clk),
    .rst_n          (rst_n),
    .lane_sums      (lane_sums),
    .mac_out_pvld   (mac_out_pvld),
    .mac_out_data   (mac_out_data)
  );

endmodule

`default_nettype wire

/* sim/tb_cmac_mac.sv */
/*
 * Testbench for the int16 MAC cell, table rows applied in a loop.
 * Constant rows carry a hand computed sum; ramp and random rows use
 * the reference model. Every result must come exactly 3 cycles after
 * its input strobe. Inputs change on the rising edge, checks on falling.
 */
`timescale 1ns/1ns
`default_nettype none

module tb_cmac_mac;

  localparam int PERIOD    = 40;
  localparam int HALF      = PERIOD / 2;
  localparam int RST_CYC   = 8;
  localparam int LATENCY   = 3;
  localparam int MAX_GAP   = 4;
  localparam int NUM_FIXED = 8;
  localparam int NUM_RAND  = 20;
  localparam int NUM_ROWS  = NUM_FIXED + NUM_RAND;
  localparam int M_CONST   = 0;
  localparam int M_RAMP    = 1;
  localparam int M_RAND    = 2;

  logic                              nvdla_core_clk;
  logic                              rst_n;
  logic                              in_pvld;
  cmac_pkg::opnd_vec_t               dat_actv_data;
  cmac_pkg::opnd_vec_t               wt_actv_data;
  logic                              mac_out_pvld;
  logic signed [cmac_pkg::SUM_W-1:0] mac_out_data;

  // ==============================
  // stimulus table and scoreboard
  // ==============================
  string  row_name [NUM_ROWS];
  int     row_mode [NUM_ROWS];
  int     row_dat  [NUM_ROWS];
  int     row_wt   [NUM_ROWS];
  int     row_gap  [NUM_ROWS];   // idle cycles before the vector
  longint row_exp  [NUM_ROWS];   // used by constant rows only

  longint              exp_q [$];
  int                  row_q [$];
  int                  cyc_q [$];   // issue cycle of each vector
  longint              pend_exp;
  int                  pend_row;
  int                  cyc_cnt;
  int                  pass_cnt;
  int                  fail_cnt;
  int                  err_cnt;
  integer              seed;
  integer              rnd;
  cmac_pkg::opnd_vec_t next_dat;
  cmac_pkg::opnd_vec_t next_wt;
  longint              model_sum;

  cmac_mac dut_i (
    .nvdla_core_clk (nvdla_core_clk),
    .rst_n          (rst_n),
    .in_pvld        (in_pvld),
    .dat_actv_data  (dat_actv_data),
    .wt_actv_data   (wt_actv_data),
    .mac_out_pvld   (mac_out_pvld),
    .mac_out_data   (mac_out_data)
  );

  initial nvdla_core_clk = 1'b0;
  always #HALF nvdla_core_clk = ~nvdla_core_clk;

  task automatic set_row(input int idx, input string name, input int mode, input int dat_base,
                         input int wt_base, input int gap, input longint exp_sum);
    row_name[idx] = name;
    row_mode[idx] = mode;
    row_dat[idx]  = dat_base;
    row_wt[idx]   = wt_base;
    row_gap[idx]  = gap;
    row_exp[idx]  = exp_sum;
  endtask

  // fills both buses for one row and returns the exact dot product
  task automatic build_vector(input int row, output cmac_pkg::opnd_vec_t dat_v,
                              output cmac_pkg::opnd_vec_t wt_v, output longint sum);
    logic signed [cmac_pkg::OPND_W-1:0] d;
    logic signed [cmac_pkg::OPND_W-1:0] w;
    int                                 tmp;
    sum = 0;
    for (int i = 0; i < cmac_pkg::NUM_PAIRS; i++) begin
      if (row_mode[row] == M_CONST) begin
        d = row_dat[row][cmac_pkg::OPND_W-1:0];
        w = row_wt[row][cmac_pkg::OPND_W-1:0];
      end else if (row_mode[row] == M_RAMP) begin
        tmp = row_dat[row] + i;
        d   = tmp[cmac_pkg::OPND_W-1:0];
        tmp = row_wt[row] - i;
        w   = tmp[cmac_pkg::OPND_W-1:0];
      end else begin
        rnd = $random(seed);      // one draw covers both operands
        d   = rnd[15:0];
        w   = rnd[31:16];
      end
      dat_v[i*cmac_pkg::OPND_W +: cmac_pkg::OPND_W] = d;
      wt_v[i*cmac_pkg::OPND_W +: cmac_pkg::OPND_W]  = w;
      sum = sum + longint'(d) * longint'(w);
    end
  endtask

  task automatic check_result();
    longint             exp_sum;
    logic signed [63:0] got;
    int                 row;
    int                 issued;
    bit                 lat_ok;
    bit                 val_ok;
    if (exp_q.size() == 0) begin
      $display("result strobe at %0t ns has no matching input vector", $time);
      err_cnt++;
    end else begin
      exp_sum = exp_q.pop_front();
      row     = row_q.pop_front();
      issued  = cyc_q.pop_front();
      got     = mac_out_data;     // sign extends to 64 bits
      lat_ok  = (cyc_cnt - issued == LATENCY);
      val_ok  = (got === exp_sum);
      assert (lat_ok) else begin
        $display("row %0d %s: result came %0d cycles after its input, not %0d",
                 row, row_name[row], cyc_cnt - issued, LATENCY);
      end
      assert (val_ok) else begin
        $display("FAILED at %0t ns: row %0d %s expected %0d, got %0d",
                 $time, row, row_name[row], exp_sum, got);
      end
      if (lat_ok && val_ok) begin
        pass_cnt++;
        $display("row %0d %s: ok, sum %0d", row, row_name[row], got);
      end else begin
        fail_cnt++;
        $display("row %0d %s: mismatch", row, row_name[row]);
      end
    end
  endtask

  // ==============================
  // monitor, sampled mid cycle
  // ==============================
  always @(negedge nvdla_core_clk) begin
    cyc_cnt = cyc_cnt + 1;
    if (!rst_n) begin
      assert (mac_out_pvld === 1'b0) else begin
        $display("mac_out_pvld went high while reset was held, at %0t ns", $time);
        err_cnt++;
      end
    end else if (mac_out_pvld === 1'b1) begin
      check_result();
    end
    if (rst_n && in_pvld === 1'b1) begin
      exp_q.push_back(pend_exp);    // stamped with the issue cycle
      row_q.push_back(pend_row);
      cyc_q.push_back(cyc_cnt);
    end
  end

  // ==============================
  // stimulus
  // ==============================
  initial begin
    seed          = 32'h4efe_0013;
    cyc_cnt       = 0;
    pass_cnt      = 0;
    fail_cnt      = 0;
    err_cnt       = 0;
    pend_exp      = 0;
    pend_row      = 0;
    rst_n         = 1'b0;
    in_pvld       = 1'b0;
    dat_actv_data = '0;
    wt_actv_data  = '0;

    set_row(0, "ones",       M_CONST, 1,      1,      2, 64);
    set_row(1, "max_pos",    M_CONST, 32767,  32767,  1, 64'sd68715282496);
    set_row(2, "mixed_sign", M_CONST, 3,      -2,     1, -384);
    set_row(3, "most_neg",   M_CONST, -32768, -32768, 0, 64'sd68719476736);
    set_row(4, "ramp_sq",    M_RAMP,  0,      0,      2, 0);
    set_row(5, "ramp_off",   M_RAMP,  -100,   50,     0, 0);
    set_row(6, "b2b_a",      M_CONST, 1,      -1,     0, -64);
    set_row(7, "b2b_b",      M_CONST, -7,     9,      0, -4032);
    for (int r = 0; r < NUM_RAND; r++) begin
      rnd = $random(seed);
      set_row(NUM_FIXED + r, $sformatf("rand_%0d", r), M_RAND, 0, 0,
              int'(rnd[7:0]) % (MAX_GAP + 1), 0);
    end

    repeat (RST_CYC) @(posedge nvdla_core_clk);
    rst_n <= 1'b1;

    for (int r = 0; r < NUM_ROWS; r++) begin
      repeat (row_gap[r]) begin
        @(posedge nvdla_core_clk);
        in_pvld <= 1'b0;
      end
      @(posedge nvdla_core_clk);
      build_vector(r, next_dat, next_wt, model_sum);
      pend_exp = (row_mode[r] == M_CONST) ? row_exp[r] : model_sum;
      pend_row = r;
      in_pvld       <= 1'b1;
      dat_actv_data <= next_dat;
      wt_actv_data  <= next_wt;
    end
    @(posedge nvdla_core_clk);
    in_pvld <= 1'b0;

    while (exp_q.size() != 0) @(negedge nvdla_core_clk);
    repeat (LATENCY + 1) @(negedge nvdla_core_clk);   // catch stray strobes

    $display("rows passed: %0d, rows failed: %0d, other errors: %0d",
             pass_cnt, fail_cnt, err_cnt);
    if (fail_cnt == 0 && err_cnt == 0 && pass_cnt == NUM_ROWS) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // ==============================
  // watchdog
  // ==============================
  initial begin
    #((RST_CYC + NUM_ROWS * (MAX_GAP + LATENCY + 2)) * PERIOD);
    $display("timeout: %0d results still outstanding at %0t ns", exp_q.size(), $time);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
common/cmac_pkg.sv
mac/cmac_operand_stage.sv
mac/cmac_mult_lane.sv
mac/cmac_sum_reduce.sv
hw/cmac_mac.sv
sim/tb_cmac_mac.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the MAC cell testbench with Verilator, run it, and judge the log.
set -u
cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  -f tb.f --top-module tb_cmac_mac -o tb_cmac_mac > "$BUILD_LOG" 2>&1 \
  && ./obj_dir/tb_cmac_mac > "$SIM_LOG" 2>&1 \
  || { cat "$BUILD_LOG" "$SIM_LOG" 2>/dev/null; echo "build or run error"; exit 1; }

cat "$SIM_LOG"
grep -q "^Simulation PASSED$" "$SIM_LOG" \
  && { echo "run_sim: test passed"; exit 0; } \
  || { echo "run_sim: test failed"; exit 1; }
